// File: logic/uart_pkg.sv
/*
 * UART transmitter shared definitions
 * Address map, widths, frame states and the decoded write word
 */
`default_nettype none

package uart_pkg;

    localparam int DATA_W   = 8;
    localparam int FIFO_AW  = 4;     // 16 slots, 15 usable
    localparam int SCALER_W = 16;
    localparam int FRAME_W  = 11;    // start, data, parity, stop
    localparam int ADDR_W   = 2;

    localparam logic [ADDR_W-1:0] ADDR_TXDATA = 2'd0;
    localparam logic [ADDR_W-1:0] ADDR_TXCTRL = 2'd1;
    localparam logic [ADDR_W-1:0] ADDR_SCALER = 2'd2;

    typedef enum logic [2:0] {
        TX_IDLE   = 3'd0,
        TX_START  = 3'd1,
        TX_DATA   = 3'd2,
        TX_PARITY = 3'd3,
        TX_STOP   = 3'd4
    } tx_state_e;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        par;    // Even parity bit enable
        logic        nstop;  // Two stop bits
        logic        ena;
    } txctrl_t;

    // One bus word, seen as a txdata character or as txctrl fields
    typedef union packed {
        logic [31:0] raw;
        txctrl_t     ctrl;
        struct packed {
            logic [31-DATA_W:0] rsvd;
            logic [DATA_W-1:0]  ch;
        } txdata;
    } wdata_u;

endpackage

`default_nettype wire

// File: logic/uart_ctrl_if.sv
/*
 * Transmit configuration bundle
 * Carries txctrl fields and the scaler from the register block
 */
`timescale 1ns/1ps
`default_nettype none

interface uart_ctrl_if import uart_pkg::*;;

    logic                ena;
    logic                nstop;
    logic                par;
    logic [SCALER_W-1:0] scaler;

    modport regs (output ena, nstop, par, scaler);
    modport baud (input scaler);
    modport ser  (input ena, nstop, par);

endinterface

`default_nettype wire

// File: logic/uart_regs.sv
/*
 * UART register decode
 * Pushes txdata into the FIFO, holds txctrl and the scaler
 */
`timescale 1ns/1ps
`default_nettype none

module uart_regs import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_wr,
    input  wire logic [ADDR_W-1:0] i_addr,
    input  wire logic [31:0]       i_wdata,
    input  wire logic              i_full,
    output logic                   o_push,
    output logic [DATA_W-1:0]      o_wdata,
    uart_ctrl_if.regs              ctrl
);

    wdata_u              wd;
    logic                ena_q;
    logic                nstop_q;
    logic                par_q;
    logic [SCALER_W-1:0] scaler_q;

    assign wd = i_wdata;

    // Writes while full are dropped
    assign o_push  = i_wr && (i_addr == ADDR_TXDATA) && !i_full;
    assign o_wdata = wd.txdata.ch;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            ena_q    <= 1'b0;
            nstop_q  <= 1'b0;
            par_q    <= 1'b0;
            scaler_q <= '0;
        end else if (i_wr) begin
            if (i_addr == ADDR_TXCTRL) begin
                ena_q   <= wd.ctrl.ena;
                nstop_q <= wd.ctrl.nstop;
                par_q   <= wd.ctrl.par;
            end
            if (i_addr == ADDR_SCALER) begin
                scaler_q <= wd.raw[SCALER_W-1:0];
            end
        end
    end

    assign ctrl.ena    = ena_q;
    assign ctrl.nstop  = nstop_q;
    assign ctrl.par    = par_q;
    assign ctrl.scaler = scaler_q;

endmodule

`default_nettype wire

// File: logic/uart_tx_fifo.sv
/*
 * Transmit FIFO, 16-entry circular byte buffer
 * Full and empty come from pointer comparison
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_push,
    input  wire logic [DATA_W-1:0] i_wdata,
    input  wire logic              i_pop,
    output logic [DATA_W-1:0]      o_rdata,
    output logic                   o_full,
    output logic                   o_empty
);

    logic [DATA_W-1:0]  mem [2**FIFO_AW];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW-1:0] wr_next;

    assign wr_next = wr_ptr + 1'b1;
    assign o_full  = (wr_next == rd_ptr);  // One slot kept free
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_rdata = mem[rd_ptr];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_next;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    a_no_pop_empty: assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_pop |-> !o_empty
    );
    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_push |-> !o_full
    );

endmodule

`default_nettype wire

// File: logic/uart_baud_gen.sv
/*
 * Baud clock scaler
 * Emits a one-cycle tick every 2*scaler system clocks
 */
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen import uart_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    uart_ctrl_if.baud ctrl,
    output logic      o_tick
);

    logic [SCALER_W-1:0] cnt;
    logic [SCALER_W-1:0] scaler_q;  // Last seen scaler
    logic [SCALER_W-1:0] cnt_last;
    logic                level;

    assign cnt_last = ctrl.scaler - 1'b1;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt      <= '0;
            scaler_q <= '0;
            level    <= 1'b1;
            o_tick   <= 1'b0;
        end else begin
            o_tick <= 1'b0;
            if (ctrl.scaler != scaler_q) begin
                // Start over at a new rate
                scaler_q <= ctrl.scaler;
                cnt      <= '0;
            end else if (ctrl.scaler != '0) begin
                if (cnt == cnt_last) begin
                    cnt    <= '0;
                    level  <= ~level;
                    o_tick <= ~level;  // Rising toggle only
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/uart_tx_serializer.sv
/*
 * Transmit frame FSM
 * Start bit, 8 data bits LSB first, optional even parity, 1 or 2 stop bits
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_tick,
    uart_ctrl_if.ser               ctrl,
    input  wire logic              i_empty,
    input  wire logic [DATA_W-1:0] i_rdata,
    output logic                   o_pop,
    output logic                   o_td
);

    tx_state_e          state;
    logic [3:0]         bit_cnt;
    logic               stop_cnt;  // Extra stop bit pending
    logic [FRAME_W-1:0] shift;
    logic               parity;

    assign parity = ^i_rdata;
    assign o_pop  = i_tick && (state == TX_IDLE) && !i_empty && ctrl.ena;
    assign o_td   = shift[0];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= TX_IDLE;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            shift    <= '1;
        end else if (i_tick) begin
            case (state)
                TX_IDLE: begin
                    if (o_pop) begin
                        // Stop, parity, data, start from MSB down
                        if (ctrl.par) begin
                            shift <= {1'b1, parity, i_rdata, 1'b0};
                        end else begin
                            shift <= {2'b11, i_rdata, 1'b0};
                        end
                        state   <= TX_START;
                        bit_cnt <= '0;
                    end else begin
                        shift <= '1;
                    end
                end
                TX_START: begin
                    state <= TX_DATA;
                end
                TX_DATA: begin
                    if (bit_cnt == 4'd8) begin
                        if (ctrl.par) begin
                            state <= TX_PARITY;
                        end else begin
                            state    <= TX_STOP;
                            stop_cnt <= ctrl.nstop;
                        end
                    end
                end
                TX_PARITY: begin
                    state    <= TX_STOP;
                    stop_cnt <= ctrl.nstop;
                end
                TX_STOP: begin
                    if (!stop_cnt) begin
                        state <= TX_IDLE;
                        shift <= '1;
                    end else begin
                        stop_cnt <= 1'b0;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    shift <= '1;
                end
            endcase

            // Shift out one bit per tick inside the frame
            if ((state != TX_IDLE) && (state != TX_STOP)) begin
                bit_cnt <= bit_cnt + 1'b1;
                shift   <= {1'b1, shift[FRAME_W-1:1]};
            end
        end
    end

    a_idle_line_high: assert property (
        @(posedge i_clk) disable iff (!i_nrst) (state == TX_IDLE) |-> o_td
    );

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
/*
 * UART transmitter top level
 * Register decode, FIFO and serializer, paced by the baud generator
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_wr,
    input  wire logic [ADDR_W-1:0] i_addr,
    input  wire logic [31:0]       i_wdata,
    output logic                   o_tx_full,
    output logic                   o_td
);

    logic              fifo_push;
    logic [DATA_W-1:0] fifo_wdata;
    logic              fifo_pop;
    logic [DATA_W-1:0] fifo_rdata;
    logic              fifo_empty;
    logic              bit_tick;

    uart_ctrl_if ctrl_if ();

    uart_regs uart_regs_inst (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_wr    (i_wr),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .i_full  (o_tx_full),
        .o_push  (fifo_push),
        .o_wdata (fifo_wdata),
        .ctrl    (ctrl_if.regs)
    );

    uart_tx_fifo uart_tx_fifo_inst (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_push  (fifo_push),
        .i_wdata (fifo_wdata),
        .i_pop   (fifo_pop),
        .o_rdata (fifo_rdata),
        .o_full  (o_tx_full),
        .o_empty (fifo_empty)
    );

    uart_baud_gen uart_baud_gen_inst (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .ctrl   (ctrl_if.baud),
        .o_tick (bit_tick)
    );

    uart_tx_serializer uart_tx_serializer_inst (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_tick  (bit_tick),
        .ctrl    (ctrl_if.ser),
        .i_empty (fifo_empty),
        .i_rdata (fifo_rdata),
        .o_pop   (fifo_pop),
        .o_td    (o_td)
    );

endmodule

`default_nettype wire

// File: tb/tb_uart_tx.sv
/*
 * UART transmitter testbench
 * Random bytes and frame settings, o_td decoded against a queue model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx import uart_pkg::*;;

    localparam int          CLK_PERIOD = 100;
    localparam int unsigned SEED       = 32'hc36ce416;

    logic              i_clk;
    logic              i_nrst;
    logic              i_wr;
    logic [ADDR_W-1:0] i_addr;
    logic [31:0]       i_wdata;
    logic              o_tx_full;
    logic              o_td;

    logic [DATA_W-1:0] exp_q [$];  // Accepted bytes not yet started
    int                accepted;
    int                starts;
    int                cfg_scaler;
    logic              cfg_ena;
    logic              cfg_par;
    logic              cfg_nstop;
    logic              busy;       // Monitor inside a frame

    uart_tx uart_tx_inst (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_wr      (i_wr),
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .o_tx_full (o_tx_full),
        .o_td      (o_td)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (exp !== got) begin
            $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s at %0t", what, $time);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic even_parity(input logic [DATA_W-1:0] b);
        logic p;
        p = 1'b0;
        for (int i = 0; i < DATA_W; i++) begin
            p = p ^ b[i];
        end
        return p;
    endfunction

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        wdata_u wd;
        logic   model_full;
        wd.raw = data;
        @(negedge i_clk);
        i_wr    = 1'b1;
        i_addr  = addr;
        i_wdata = data;
        if (addr == ADDR_TXDATA) begin
            #(CLK_PERIOD/4);  // Start bits of this edge already counted
            model_full = ((accepted - starts) == 2**FIFO_AW - 1);
            expect_equal("o_tx_full", 32'(model_full), 32'(o_tx_full));
            if (!model_full) begin
                exp_q.push_back(wd.txdata.ch);
                accepted++;
            end
        end
        @(negedge i_clk);
        i_wr = 1'b0;
    endtask

    task automatic set_config(input int scl, input logic en, input logic p, input logic ns);
        wdata_u w;
        w.raw = $urandom;
        w.raw[SCALER_W-1:0] = scl[SCALER_W-1:0];
        bus_write(ADDR_SCALER, w.raw);
        w.raw        = $urandom;  // Filler bits random too
        w.ctrl.ena   = en;
        w.ctrl.nstop = ns;
        w.ctrl.par   = p;
        bus_write(ADDR_TXCTRL, w.raw);
        cfg_scaler = scl;
        cfg_ena    = en;
        cfg_par    = p;
        cfg_nstop  = ns;
    endtask

    task automatic hold_line_high(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            expect_equal("o_td idle", 32'(1'b1), 32'(o_td));
        end
    endtask

    task automatic wait_drain();
        int limit;
        int waited;
        limit  = (exp_q.size() + 2) * 12 * 2 * cfg_scaler + 100;
        waited = 0;
        while (exp_q.size() != 0 || busy) begin
            @(negedge i_clk);
            waited++;
            if (waited > limit) begin
                fail_run("Timeout waiting for the queued bytes to go out");
            end
        end
        repeat (2 * cfg_scaler) @(negedge i_clk);  // Rest of the last stop bit
    endtask

    // Frame decoder sampling each bit near its middle
    initial begin : line_monitor
        logic              td_prev;
        logic [DATA_W-1:0] exp_byte;
        logic [DATA_W-1:0] got;
        int                idle;
        td_prev = 1'b1;
        idle    = 0;
        starts  = 0;
        busy    = 1'b0;
        forever begin
            @(negedge i_clk);
            if (td_prev && !o_td) begin
                if (!cfg_ena || exp_q.size() == 0) begin
                    fail_run("Start bit seen with no byte expected");
                end else begin
                    exp_byte = exp_q.pop_front();
                    starts++;
                    busy = 1'b1;
                    repeat (cfg_scaler) @(negedge i_clk);
                    expect_equal("o_td start bit", 32'(1'b0), 32'(o_td));
                    for (int i = 0; i < DATA_W; i++) begin
                        repeat (2 * cfg_scaler) @(negedge i_clk);
                        got[i] = o_td;  // LSB first
                    end
                    expect_equal("o_td data byte", 32'(exp_byte), 32'(got));
                    if (cfg_par) begin
                        repeat (2 * cfg_scaler) @(negedge i_clk);
                        expect_equal("o_td parity bit", 32'(even_parity(exp_byte)),
                                     32'(o_td));
                    end
                    repeat (cfg_nstop ? 2 : 1) begin
                        repeat (2 * cfg_scaler) @(negedge i_clk);
                        expect_equal("o_td stop bit", 32'(1'b1), 32'(o_td));
                    end
                    busy = 1'b0;
                end
                idle = 0;
            end else if (cfg_ena && exp_q.size() != 0) begin
                idle++;
                if (idle > 8 * cfg_scaler + 40) begin
                    fail_run("Timeout waiting for a start bit");
                end
            end else begin
                idle = 0;
            end
            td_prev = o_td;
        end
    end

    initial begin : stimulus
        int n;
        void'($urandom(SEED));
        i_nrst     = 1'b0;
        i_wr       = 1'b0;
        i_addr     = '0;
        i_wdata    = '0;
        accepted   = 0;
        cfg_scaler = 0;
        cfg_ena    = 1'b0;
        cfg_par    = 1'b0;
        cfg_nstop  = 1'b0;
        repeat (3) @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);
        expect_equal("o_td", 32'(1'b1), 32'(o_td));
        expect_equal("o_tx_full", 32'(1'b0), 32'(o_tx_full));

        // Disabled transmitter keeps the line high
        set_config(3, 1'b0, 1'b0, 1'b0);
        repeat (4) bus_write(ADDR_TXDATA, $urandom);
        hold_line_high(10 * 2 * cfg_scaler);
        set_config(3, 1'b1, 1'b0, 1'b0);
        wait_drain();

        // Fill past full with the serializer stopped
        set_config($urandom_range(2, 6), 1'b0, 1'($urandom_range(0, 1)),
                   1'($urandom_range(0, 1)));
        repeat (18) bus_write(ADDR_TXDATA, $urandom);
        hold_line_high(4 * 2 * cfg_scaler);
        set_config(cfg_scaler, 1'b1, cfg_par, cfg_nstop);
        wait_drain();

        // Every par/nstop pair first, then random ones
        for (int r = 0; r < 8; r++) begin
            n = (r < 4) ? r : $urandom_range(0, 3);
            set_config($urandom_range(2, 6), 1'b1, n[1], n[0]);
            repeat ($urandom_range(3, 10)) begin
                bus_write(ADDR_TXDATA, $urandom);
                repeat ($urandom_range(0, 6 * cfg_scaler)) @(negedge i_clk);
            end
            wait_drain();
        end

        // Burst that overruns the FIFO while sending
        set_config(6, 1'b1, 1'b1, 1'b1);
        repeat (20) bus_write(ADDR_TXDATA, $urandom);
        wait_drain();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_tx.f
logic/uart_pkg.sv
logic/uart_ctrl_if.sv
logic/uart_regs.sv
logic/uart_tx_fifo.sv
logic/uart_baud_gen.sv
logic/uart_tx_serializer.sv
logic/uart_tx.sv
tb/tb_uart_tx.sv

// File: Makefile
all: run

run: obj_dir/Vtb_uart_tx
	./obj_dir/Vtb_uart_tx

obj_dir/Vtb_uart_tx: uart_tx.f $(wildcard logic/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module tb_uart_tx -f uart_tx.f

lint:
	verilator --lint-only --timing -Wall --top-module uart_tx -f uart_tx.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
